/* files.f */
+incdir+hdl
hdl/mem_types_pkg.sv
hdl/lsq_types_pkg.sv
hdl/store_queue.sv
hdl/load_queue.sv
hdl/lsq_mem_arbiter.sv
hdl/lsq_top.sv
testbench/tb_clock_gen.sv
testbench/tb_lsq_top.sv

/* hdl/load_queue.sv */
`include "lsq_macros.svh"

module load_queue (
    input  logic                      clock,
    input  logic                      rst_n_i,
    input  logic                      enq_valid_i,
    input  lsq_types_pkg::dispatch_t  enq_i,
    input  lsq_types_pkg::sq_idx_t    sq_tail_i,   // Age mark for forwarding
    input  lsq_types_pkg::fwd_resp_t  fwd_resp_i,
    input  logic                      req_grant_i,
    input  mem_types_pkg::mem_resp_t  resp_i,
    input  logic                      commit_valid_i,
    input  lsq_types_pkg::rob_idx_t   commit_rob_i,
    output logic                      full_o,
    output lsq_types_pkg::fwd_query_t fwd_query_o,
    output logic                      req_valid_o,
    output mem_types_pkg::mem_req_t   req_o,
    output lsq_types_pkg::wb_t        wb_o
);
    import mem_types_pkg::*;
    import lsq_types_pkg::*;

    localparam int DEPTH = `LSQ_LQ_DEPTH;

    lq_state_e  state_q [DEPTH];
    addr_t      addr_q  [DEPTH];
    mem_size_e  size_q  [DEPTH];
    rob_idx_t   rob_q   [DEPTH];
    sq_idx_t    age_q   [DEPTH];
    mem_block_t data_q  [DEPTH];

    lq_idx_t                 head_q;
    lq_idx_t                 tail_q;
    logic [$clog2(DEPTH):0]  count_q;
    logic                    do_enq;
    logic                    do_retire;
    logic                    fwd_hit;
    logic                    q_found;  // Some entry is READY
    lq_idx_t                 q_idx;    // Oldest READY
    logic                    wb_found;
    lq_idx_t                 wb_idx;   // Oldest DONE

    assign full_o    = (count_q == DEPTH[$clog2(DEPTH):0]);
    assign do_enq    = enq_valid_i && !full_o;
    assign do_retire = commit_valid_i && state_q[head_q] == LQ_WRITTEN &&
                       rob_q[head_q] == commit_rob_i;
    assign fwd_hit   = q_found && fwd_resp_i.hit;

    // Oldest READY and oldest DONE, walking from the head
    always_comb begin
        lq_idx_t idx;
        q_found  = 1'b0;
        q_idx    = head_q;
        wb_found = 1'b0;
        wb_idx   = head_q;
        for (int k = 0; k < DEPTH; k++) begin
            idx = head_q + lq_idx_t'(k);
            if (!q_found && state_q[idx] == LQ_READY) begin
                q_found = 1'b1;
                q_idx   = idx;
            end
            if (!wb_found && state_q[idx] == LQ_DONE) begin
                wb_found = 1'b1;
                wb_idx   = idx;
            end
        end
    end

    // =========================================================
    // SQ query and memory issue
    // =========================================================
    assign fwd_query_o = '{valid: q_found,
                           addr:  addr_q[q_idx],
                           size:  size_q[q_idx],
                           age:   age_q[q_idx]};

    // Miss goes to memory, pending simply asks again next cycle
    assign req_valid_o = q_found && !fwd_resp_i.hit && !fwd_resp_i.pending;
    assign req_o       = '{cmd:  MEM_LOAD,
                           addr: addr_q[q_idx],
                           size: size_q[q_idx],
                           data: '0,
                           tag:  q_idx};

    assign wb_o = '{valid: wb_found, rob: rob_q[wb_idx], data: data_q[wb_idx]};

    // =========================================================
    // Entry state machine
    // =========================================================
    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < DEPTH; i++)
                state_q[i] <= LQ_FREE;
        end else begin
            if (do_enq) begin
                state_q[tail_q] <= LQ_READY;
                tail_q          <= tail_q + 1'b1;
            end
            if (fwd_hit)
                state_q[q_idx] <= LQ_DONE;  // Forwarded, skip memory
            else if (req_valid_o && req_grant_i)
                state_q[q_idx] <= LQ_ISSUED;
            if (resp_i.valid && state_q[resp_i.tag] == LQ_ISSUED)
                state_q[resp_i.tag] <= LQ_DONE;
            if (wb_found)
                state_q[wb_idx] <= LQ_WRITTEN; // One writeback cycle per load
            if (do_retire) begin
                state_q[head_q] <= LQ_FREE;
                head_q          <= head_q + 1'b1;
            end
            if (do_enq && !do_retire)
                count_q <= count_q + 1'b1;
            else if (!do_enq && do_retire)
                count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (do_enq) begin
            addr_q[tail_q] <= enq_i.addr;
            size_q[tail_q] <= enq_i.size;
            rob_q[tail_q]  <= enq_i.rob;
            age_q[tail_q]  <= sq_tail_i;
        end
        if (fwd_hit)
            data_q[q_idx] <= fwd_resp_i.data;
        if (resp_i.valid && state_q[resp_i.tag] == LQ_ISSUED)
            data_q[resp_i.tag] <= resp_i.data;
    end

endmodule

/* hdl/lsq_macros.svh */
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// =========================================================
// Datapath widths
// =========================================================
`define LSQ_ADDR_W 32 // Byte address
`define LSQ_DATA_W 32 // One memory word
`define LSQ_ROB_W  5  // 32 ROB slots

// =========================================================
// Queue sizing
// =========================================================
`define LSQ_SQ_DEPTH 8 // Power of two so pointers wrap on their own
`define LSQ_LQ_DEPTH 8
// Committed stores waiting before stores take the port from loads
`define LSQ_DRAIN_THRESH 4

`endif

/* hdl/lsq_mem_arbiter.sv */
`include "lsq_macros.svh"

module lsq_mem_arbiter (
    input  logic                     clock,
    input  logic                     rst_n_i,
    input  logic                     st_valid_i,
    input  mem_types_pkg::mem_req_t  st_req_i,
    input  lsq_types_pkg::sq_cnt_t   st_pressure_i, // Committed stores in SQ
    input  logic                     ld_valid_i,
    input  mem_types_pkg::mem_req_t  ld_req_i,
    input  logic                     mem_accept_i,
    input  mem_types_pkg::mem_resp_t mem_resp_i,
    output logic                     st_grant_o,
    output logic                     ld_grant_o,
    output logic                     mem_req_valid_o,
    output mem_types_pkg::mem_req_t  mem_req_o,
    output mem_types_pkg::mem_resp_t ld_resp_o
);
    import mem_types_pkg::*;
    import lsq_types_pkg::*;

    logic                     lock_q;    // Request shown but not yet taken
    logic                     lock_st_q; // Owner while locked
    logic                     pick_st;
    logic [`LSQ_LQ_DEPTH-1:0] inflight_q; // Load tags awaiting data

    // Loads first unless stores have piled up or loads are idle
    assign pick_st = lock_q ? lock_st_q :
                     (st_valid_i && (!ld_valid_i ||
                      st_pressure_i >= sq_cnt_t'(`LSQ_DRAIN_THRESH)));

    assign mem_req_valid_o = pick_st ? st_valid_i : ld_valid_i;
    assign st_grant_o      = pick_st && st_valid_i && mem_accept_i;
    assign ld_grant_o      = !pick_st && ld_valid_i && mem_accept_i;

    always_comb begin
        mem_req_o = pick_st ? st_req_i : ld_req_i;
        if (!mem_req_valid_o)
            mem_req_o.cmd = MEM_NONE; // Idle port
    end

    // Only tags that went out are passed on
    always_comb begin
        ld_resp_o       = mem_resp_i;
        ld_resp_o.valid = mem_resp_i.valid && inflight_q[mem_resp_i.tag];
    end

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lock_q     <= 1'b0;
            lock_st_q  <= 1'b0;
            inflight_q <= '0;
        end else begin
            lock_q    <= mem_req_valid_o && !mem_accept_i; // Hold the choice
            lock_st_q <= pick_st;
            if (ld_resp_o.valid)
                inflight_q[mem_resp_i.tag] <= 1'b0;
            if (ld_grant_o)
                inflight_q[ld_req_i.tag] <= 1'b1;
        end
    end

endmodule

/* hdl/lsq_top.sv */
module lsq_top (
    input  logic                      clock,
    input  logic                      rst_n_i,
    // Dispatch
    input  logic                      dispatch_valid_i,
    input  logic                      dispatch_is_store_i, // 1 store, 0 load
    input  lsq_types_pkg::dispatch_t  dispatch_i,
    // Store data from execute
    input  logic                      st_data_valid_i,
    input  lsq_types_pkg::rob_idx_t   st_data_rob_i,
    input  mem_types_pkg::mem_block_t st_data_i,
    // ROB commit
    input  logic                      commit_valid_i,
    input  lsq_types_pkg::rob_idx_t   commit_rob_i,
    // Data cache port
    input  logic                      mem_accept_i,
    input  mem_types_pkg::mem_resp_t  mem_resp_i,
    output logic                      lsq_full_o,      // Stall to frontend
    output logic                      mem_req_valid_o,
    output mem_types_pkg::mem_req_t   mem_req_o,
    output lsq_types_pkg::wb_t        wb_o
);
    import mem_types_pkg::*;
    import lsq_types_pkg::*;

    logic       sq_full, lq_full;
    sq_idx_t    sq_tail;
    fwd_query_t fwd_query;
    fwd_resp_t  fwd_resp;
    logic       sq_req_valid, sq_grant;
    mem_req_t   sq_req;
    sq_cnt_t    sq_committed;
    logic       lq_req_valid, lq_grant;
    mem_req_t   lq_req;
    mem_resp_t  lq_resp;

    // =========================================================
    // Dispatch steering
    // =========================================================
    assign lsq_full_o = dispatch_is_store_i ? sq_full : lq_full;

    store_queue u_sq (
        .clock             (clock),
        .rst_n_i           (rst_n_i),
        .enq_valid_i       (dispatch_valid_i && dispatch_is_store_i),
        .enq_i             (dispatch_i),
        .data_valid_i      (st_data_valid_i),
        .data_rob_i        (st_data_rob_i),
        .data_i            (st_data_i),
        .commit_valid_i    (commit_valid_i),
        .commit_rob_i      (commit_rob_i),
        .fwd_query_i       (fwd_query),
        .drain_grant_i     (sq_grant),
        .full_o            (sq_full),
        .tail_o            (sq_tail),
        .fwd_resp_o        (fwd_resp),
        .drain_valid_o     (sq_req_valid),
        .drain_req_o       (sq_req),
        .committed_count_o (sq_committed)
    );

    load_queue u_lq (
        .clock          (clock),
        .rst_n_i        (rst_n_i),
        .enq_valid_i    (dispatch_valid_i && !dispatch_is_store_i),
        .enq_i          (dispatch_i),
        .sq_tail_i      (sq_tail),
        .fwd_resp_i     (fwd_resp),
        .req_grant_i    (lq_grant),
        .resp_i         (lq_resp),
        .commit_valid_i (commit_valid_i),
        .commit_rob_i   (commit_rob_i),
        .full_o         (lq_full),
        .fwd_query_o    (fwd_query),
        .req_valid_o    (lq_req_valid),
        .req_o          (lq_req),
        .wb_o           (wb_o)
    );

    // Single cache port shared by drains and loads
    lsq_mem_arbiter u_arb (
        .clock           (clock),
        .rst_n_i         (rst_n_i),
        .st_valid_i      (sq_req_valid),
        .st_req_i        (sq_req),
        .st_pressure_i   (sq_committed),
        .ld_valid_i      (lq_req_valid),
        .ld_req_i        (lq_req),
        .mem_accept_i    (mem_accept_i),
        .mem_resp_i      (mem_resp_i),
        .st_grant_o      (sq_grant),
        .ld_grant_o      (lq_grant),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .ld_resp_o       (lq_resp)
    );

endmodule

/* hdl/lsq_types_pkg.sv */
`include "lsq_macros.svh"

// Types shared between the two queues and the core
package lsq_types_pkg;

    import mem_types_pkg::*;

    typedef logic [`LSQ_ROB_W-1:0]            rob_idx_t;
    typedef logic [$clog2(`LSQ_SQ_DEPTH)-1:0] sq_idx_t;
    typedef logic [$clog2(`LSQ_SQ_DEPTH):0]   sq_cnt_t; // 0 .. SQ depth
    typedef mem_tag_t                         lq_idx_t; // Slot doubles as memory tag

    // One dispatched memory op
    typedef struct packed {
        addr_t     addr;
        mem_size_e size;
        rob_idx_t  rob;
    } dispatch_t;

    // LQ asks the SQ about older stores
    typedef struct packed {
        logic      valid;
        addr_t     addr;
        mem_size_e size;
        sq_idx_t   age; // SQ tail seen at load dispatch
    } fwd_query_t;

    typedef struct packed {
        logic       hit;     // Exact match with data
        logic       pending; // Overlap that must resolve first
        mem_block_t data;
    } fwd_resp_t;

    typedef struct packed {
        logic       valid;
        rob_idx_t   rob;
        mem_block_t data;
    } wb_t;

    typedef enum logic [2:0] {
        LQ_FREE,
        LQ_READY,   // Waiting to query the SQ
        LQ_ISSUED,  // Sent to memory
        LQ_DONE,    // Data held, waiting for writeback
        LQ_WRITTEN  // Written back, waiting for commit
    } lq_state_e;

endpackage

/* hdl/mem_types_pkg.sv */
`include "lsq_macros.svh"

// Types seen on the data-cache side of the LSQ
package mem_types_pkg;

    typedef logic [`LSQ_ADDR_W-1:0] addr_t;      // Byte address
    typedef logic [`LSQ_DATA_W-1:0] mem_block_t; // Sub-word data sits in the low bytes
    typedef logic [$clog2(`LSQ_LQ_DEPTH)-1:0] mem_tag_t; // LQ slot of a load

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_cmd_e;

    typedef struct packed {
        mem_cmd_e   cmd;
        addr_t      addr;
        mem_size_e  size;
        mem_block_t data; // Store data, zero for loads
        mem_tag_t   tag;  // Echoed back with the load response
    } mem_req_t;

    // Load data comes back zero extended
    typedef struct packed {
        logic       valid;
        mem_tag_t   tag;
        mem_block_t data;
    } mem_resp_t;

endpackage

/* hdl/store_queue.sv */
`include "lsq_macros.svh"

module store_queue (
    input  logic                      clock,
    input  logic                      rst_n_i,
    input  logic                      enq_valid_i,
    input  lsq_types_pkg::dispatch_t  enq_i,
    input  logic                      data_valid_i,   // Store data from execute
    input  lsq_types_pkg::rob_idx_t   data_rob_i,
    input  mem_types_pkg::mem_block_t data_i,
    input  logic                      commit_valid_i, // ROB retire
    input  lsq_types_pkg::rob_idx_t   commit_rob_i,
    input  lsq_types_pkg::fwd_query_t fwd_query_i,
    input  logic                      drain_grant_i,
    output logic                      full_o,
    output lsq_types_pkg::sq_idx_t    tail_o,
    output lsq_types_pkg::fwd_resp_t  fwd_resp_o,
    output logic                      drain_valid_o,
    output mem_types_pkg::mem_req_t   drain_req_o,
    output lsq_types_pkg::sq_cnt_t    committed_count_o
);
    import mem_types_pkg::*;
    import lsq_types_pkg::*;

    localparam int DEPTH = `LSQ_SQ_DEPTH;

    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] has_data_q;  // Data captured
    logic [DEPTH-1:0] committed_q; // Safe to write to memory

    addr_t      addr_q [DEPTH];
    mem_size_e  size_q [DEPTH];
    rob_idx_t   rob_q  [DEPTH];
    mem_block_t data_q [DEPTH];

    sq_idx_t head_q;
    sq_idx_t tail_q;
    sq_cnt_t count_q;
    logic    do_enq;
    logic    do_deq;
    sq_idx_t older_n;  // Stores ahead of the querying load
    sq_idx_t scan_idx;

    // Bytes a load of this size gets back
    function automatic mem_block_t size_mask(input mem_size_e size, input mem_block_t d);
        case (size)
            MEM_BYTE: size_mask = mem_block_t'(d[7:0]);
            MEM_HALF: size_mask = mem_block_t'(d[15:0]);
            default:  size_mask = d;
        endcase
    endfunction

    assign full_o = (count_q == sq_cnt_t'(DEPTH));
    assign tail_o = tail_q;
    assign do_enq = enq_valid_i && !full_o;
    assign do_deq = drain_valid_o && drain_grant_i;

    // =========================================================
    // Allocation, data capture, commit marking
    // =========================================================
    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q      <= '0;
            tail_q      <= '0;
            count_q     <= '0;
            valid_q     <= '0;
            has_data_q  <= '0;
            committed_q <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (valid_q[i] && data_valid_i && rob_q[i] == data_rob_i)
                    has_data_q[i] <= 1'b1;
                if (valid_q[i] && commit_valid_i && rob_q[i] == commit_rob_i)
                    committed_q[i] <= 1'b1;
            end
            if (do_enq) begin
                valid_q[tail_q]     <= 1'b1;
                has_data_q[tail_q]  <= 1'b0;
                committed_q[tail_q] <= 1'b0;
                tail_q              <= tail_q + 1'b1;
            end
            if (do_deq) begin
                valid_q[head_q] <= 1'b0; // Memory took the store
                head_q          <= head_q + 1'b1;
            end
            if (do_enq && !do_deq)
                count_q <= count_q + 1'b1;
            else if (!do_enq && do_deq)
                count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (do_enq) begin
            addr_q[tail_q] <= enq_i.addr;
            size_q[tail_q] <= enq_i.size;
            rob_q[tail_q]  <= enq_i.rob;
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (valid_q[i] && data_valid_i && rob_q[i] == data_rob_i)
                data_q[i] <= data_i;
        end
    end

    // =========================================================
    // Forwarding search
    // =========================================================
    always_comb begin
        fwd_resp_o = '0;
        older_n    = fwd_query_i.age - head_q; // Circular distance to the mark
        scan_idx   = head_q;
        // Oldest to youngest so the youngest older store wins
        for (int k = 0; k < DEPTH; k++) begin
            scan_idx = head_q + sq_idx_t'(k);
            if (fwd_query_i.valid && valid_q[scan_idx] && k < int'(older_n) &&
                addr_q[scan_idx][$bits(addr_t)-1:2] == fwd_query_i.addr[$bits(addr_t)-1:2]) begin
                if (has_data_q[scan_idx] && addr_q[scan_idx] == fwd_query_i.addr &&
                    size_q[scan_idx] == fwd_query_i.size) begin
                    fwd_resp_o.hit     = 1'b1;
                    fwd_resp_o.pending = 1'b0;
                    fwd_resp_o.data    = size_mask(size_q[scan_idx], data_q[scan_idx]);
                end else begin
                    fwd_resp_o.hit     = 1'b0; // Same word, cannot forward yet
                    fwd_resp_o.pending = 1'b1;
                end
            end
        end
    end

    // =========================================================
    // Drain to memory
    // =========================================================
    assign drain_valid_o = valid_q[head_q] && committed_q[head_q] && has_data_q[head_q];
    assign drain_req_o   = '{cmd:  MEM_STORE,
                             addr: addr_q[head_q],
                             size: size_q[head_q],
                             data: data_q[head_q],
                             tag:  '0};

    // Drain pressure for the arbiter
    always_comb begin
        committed_count_o = '0;
        for (int i = 0; i < DEPTH; i++)
            committed_count_o = committed_count_o + sq_cnt_t'(valid_q[i] & committed_q[i]);
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the LSQ testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_lsq_top -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
fi
exit 1

/* testbench/lsq_cases.txt */
# cmd name args: P addr data | L/S rob addr size | D rob data | C rob | I cycles
# W rob expected_data | F is_store expected_full (hex addr/data, size 0 byte 1 half 2 word)
P t1_mem_load 100 cafef00d
L t1_mem_load 0 100 2
W t1_mem_load 0 cafef00d
C t1_mem_load 0
P t2_forward 200 dead0000
S t2_forward 1 200 2
L t2_forward 2 200 2
D t2_forward 1 12345678
W t2_forward 2 12345678
C t2_forward 1
C t2_forward 2
S t3_overlap 3 300 2
D t3_overlap 3 11223344
L t3_overlap 4 301 0
I t3_overlap 6
C t3_overlap 3
W t3_overlap 4 33
C t3_overlap 4
S t4_full 5 400 2
S t4_full 6 404 2
S t4_full 7 408 2
S t4_full 8 40c 2
S t4_full 9 410 2
S t4_full 10 414 2
S t4_full 11 418 2
S t4_full 12 41c 2
F t4_full 1 1
D t4_full 5 5a000400
D t4_full 6 5a000404
D t4_full 7 5a000408
D t4_full 8 5a00040c
D t4_full 9 5a000410
D t4_full 10 5a000414
D t4_full 11 5a000418
D t4_full 12 5a00041c
C t4_full 5
C t4_full 6
C t4_full 7
C t4_full 8
C t4_full 9
C t4_full 10
C t4_full 11
C t4_full 12
I t4_full 40
F t4_clear 1 0
L t4_load 13 404 2
L t4_load 14 41c 2
W t4_load 13 5a000404
W t4_load 14 5a00041c
C t4_load 13
C t4_load 14
P t5_random 500 01020304
P t5_random 504 0a0b0c0d
P t5_random 508 10203040
P t5_random 50c f00dface
P t5_random 510 7788beef
P t5_random 514 99aabbcc
L t5_random 15 500 2
L t5_random 16 504 2
L t5_random 17 508 2
L t5_random 18 50c 2
L t5_random 19 512 1
L t5_random 20 517 0
W t5_random 18 f00dface
W t5_random 16 0a0b0c0d
W t5_random 20 99
W t5_random 15 01020304
W t5_random 19 7788
W t5_random 17 10203040
C t5_random 15
C t5_random 16
C t5_random 17
C t5_random 18
C t5_random 19
C t5_random 20

/* testbench/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clock_o,
    output logic rst_n_o
);

    // Period of 40
    initial begin
        clock_o = 1'b0;
        forever #20 clock_o = ~clock_o;
    end

    // Reset held low for 4 rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clock_o);
        #5 rst_n_o = 1'b1;
    end

endmodule

/* testbench/tb_lsq_top.sv */
module tb_lsq_top;
    import mem_types_pkg::*;
    import lsq_types_pkg::*;

    logic       clock;
    logic       rst_n;
    logic       dispatch_valid_i;
    logic       dispatch_is_store_i;
    dispatch_t  dispatch_i;
    logic       st_data_valid_i;
    rob_idx_t   st_data_rob_i;
    mem_block_t st_data_i;
    logic       commit_valid_i;
    rob_idx_t   commit_rob_i;
    logic       mem_accept_i = 1'b0; // Memory process owns these two
    mem_resp_t  mem_resp_i = '0;
    logic       lsq_full_o;
    logic       mem_req_valid_o;
    mem_req_t   mem_req_o;
    wb_t        wb_o;

    logic [7:0]  pre_mem [addr_t]; // Preloaded bytes
    logic [7:0]  st_mem  [addr_t]; // Bytes written by drained stores
    int          pend_due [$];     // Outstanding load responses
    mem_tag_t    pend_tag [$];
    mem_block_t  pend_data [$];
    logic [15:0] lfsr_q = 16'd15383;
    int          cycle_cnt = 0;
    int          limit = 1000000;  // Replaced once the case file is read
    int          errors = 0;       // Main process
    int          mon_errors = 0;   // Memory and writeback process
    int          seen_cnt [32];    // Writebacks per ROB index
    mem_block_t  seen_data [32];
    string       lines [$];
    string       missing [$];

    tb_clock_gen u_clk (.clock_o(clock), .rst_n_o(rst_n));

    lsq_top DUT (
        .clock               (clock),
        .rst_n_i             (rst_n),
        .dispatch_valid_i    (dispatch_valid_i),
        .dispatch_is_store_i (dispatch_is_store_i),
        .dispatch_i          (dispatch_i),
        .st_data_valid_i     (st_data_valid_i),
        .st_data_rob_i       (st_data_rob_i),
        .st_data_i           (st_data_i),
        .commit_valid_i      (commit_valid_i),
        .commit_rob_i        (commit_rob_i),
        .mem_accept_i        (mem_accept_i),
        .mem_resp_i          (mem_resp_i),
        .lsq_full_o          (lsq_full_o),
        .mem_req_valid_o     (mem_req_valid_o),
        .mem_req_o           (mem_req_o),
        .wb_o                (wb_o)
    );

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] read_byte(input addr_t a);
        if (st_mem.exists(a))
            return st_mem[a];
        else if (pre_mem.exists(a))
            return pre_mem[a];
        else
            return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0]; // Untouched bytes
    endfunction

    // Zero extended little-endian read
    function automatic mem_block_t read_mem(input addr_t a, input mem_size_e size);
        mem_block_t d;
        d = '0;
        for (int i = 0; i < (1 << size); i++)
            d[8*i +: 8] = read_byte(a + addr_t'(i));
        return d;
    endfunction

    // ============================================================
    // Memory model, writeback tracker, timeout
    // ============================================================
    always @(posedge clock) begin
        int idx;
        int lat;
        cycle_cnt++;
        if (cycle_cnt >= limit) begin
            $display("Timeout after %0d cycles, run stopped", cycle_cnt);
            $display("TESTS FAILED");
            $finish;
        end else begin
            if (rst_n && mem_req_valid_o && mem_accept_i) begin
                if (mem_req_o.cmd == MEM_STORE) begin
                    for (int i = 0; i < (1 << mem_req_o.size); i++)
                        st_mem[mem_req_o.addr + addr_t'(i)] = mem_req_o.data[8*i +: 8];
                end else if (mem_req_o.cmd == MEM_LOAD) begin
                    lat = 2 + int'(lfsr_bit()); // 2 to 5 cycles
                    lat = lat + 2 * int'(lfsr_bit());
                    pend_due.push_back(cycle_cnt + lat);
                    pend_tag.push_back(mem_req_o.tag);
                    pend_data.push_back(read_mem(mem_req_o.addr, mem_req_o.size));
                end
            end
            if (rst_n && wb_o.valid) begin
                if (seen_cnt[wb_o.rob] != 0) begin
                    mon_errors++;
                    $display("ROB %0d written back more than once", wb_o.rob);
                end
                seen_cnt[wb_o.rob]++;
                seen_data[wb_o.rob] = wb_o.data;
            end
            #5;
            idx = -1;
            foreach (pend_due[i])
                if (idx < 0 && pend_due[i] <= cycle_cnt)
                    idx = i; // First due goes out so order follows latency
            mem_resp_i = '0;
            if (idx >= 0) begin
                mem_resp_i.valid = 1'b1;
                mem_resp_i.tag   = pend_tag[idx];
                mem_resp_i.data  = pend_data[idx];
                pend_due.delete(idx);
                pend_tag.delete(idx);
                pend_data.delete(idx);
            end
            mem_accept_i = lfsr_bit(); // Random back-pressure
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Holds the op until the addressed queue has room
    task automatic dispatch_op(input logic is_store, input rob_idx_t rob,
                               input addr_t addr, input mem_size_e size);
        dispatch_valid_i    = 1'b1;
        dispatch_is_store_i = is_store;
        dispatch_i          = '{addr: addr, size: size, rob: rob};
        do @(posedge clock); while (lsq_full_o);
        #5 dispatch_valid_i = 1'b0;
    endtask

    task automatic deliver_data(input rob_idx_t rob, input mem_block_t d);
        st_data_valid_i = 1'b1;
        st_data_rob_i   = rob;
        st_data_i       = d;
        @(posedge clock);
        #5 st_data_valid_i = 1'b0;
    endtask

    task automatic commit_op(input rob_idx_t rob);
        commit_valid_i = 1'b1;
        commit_rob_i   = rob;
        @(posedge clock);
        #5 commit_valid_i = 1'b0;
    endtask

    task automatic expect_wb(input string name, input rob_idx_t rob, input mem_block_t d);
        for (int w = 0; w < 300 && seen_cnt[rob] == 0; w++)
            @(posedge clock);
        if (seen_cnt[rob] == 0)
            missing.push_back(name);
        else
            check_value(name, d, seen_data[rob]);
        #5;
    endtask

    task automatic run_line(input string line);
        string       cmd;
        string       name;
        int          n1;
        int          n2;
        logic [31:0] a1;
        logic [31:0] a2;
        int          rc;
        int          want;   // Fields the command needs
        rc   = $sscanf(line, "%s %s", cmd, name);
        want = 2;
        case (cmd)
            "P": begin
                rc   = $sscanf(line, "%s %s %h %h", cmd, name, a1, a2);
                want = 4;
                for (int i = 0; i < 4; i++)
                    pre_mem[a1 + addr_t'(i)] = a2[8*i +: 8];
            end
            "L", "S": begin
                rc   = $sscanf(line, "%s %s %d %h %d", cmd, name, n1, a1, n2);
                want = 5;
                dispatch_op(cmd == "S", 5'(n1), a1, mem_size_e'(2'(n2)));
            end
            "D": begin
                rc   = $sscanf(line, "%s %s %d %h", cmd, name, n1, a1);
                want = 4;
                deliver_data(5'(n1), a1);
            end
            "C": begin
                rc   = $sscanf(line, "%s %s %d", cmd, name, n1);
                want = 3;
                commit_op(5'(n1));
            end
            "I": begin
                rc   = $sscanf(line, "%s %s %d", cmd, name, n1);
                want = 3;
                repeat (n1) @(posedge clock);
                #5;
            end
            "W": begin
                rc   = $sscanf(line, "%s %s %d %h", cmd, name, n1, a1);
                want = 4;
                expect_wb(name, 5'(n1), a1);
            end
            "F": begin
                rc   = $sscanf(line, "%s %s %d %h", cmd, name, n1, a1);
                want = 4;
                dispatch_is_store_i = (n1 != 0); // Selects which queue is reported
                @(posedge clock);
                check_value(name, a1, 32'(lsq_full_o));
                #5;
            end
            default: begin
                want = rc;
                errors++;
                $display("Unknown command in case line: %s", line);
            end
        endcase
        if (rc != want) begin
            errors++;
            $display("Case line has missing or bad fields: %s", line);
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        int    fd;
        int    total;
        string line;
        dispatch_valid_i    = 1'b0;
        dispatch_is_store_i = 1'b0;
        dispatch_i          = '0;
        st_data_valid_i     = 1'b0;
        st_data_rob_i       = '0;
        st_data_i           = '0;
        commit_valid_i      = 1'b0;
        commit_rob_i        = '0;
        fd = $fopen("testbench/lsq_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the case file testbench/lsq_cases.txt");
            $display("TESTS FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != 8'h23)
                    lines.push_back(line); // Skip comments and blank lines
            end
            $fclose(fd);
            limit = lines.size() * 40;
            wait (rst_n === 1'b1);
            @(posedge clock);
            check_value("reset_full", 32'd0, 32'(lsq_full_o));
            check_value("reset_req_valid", 32'd0, 32'(mem_req_valid_o));
            check_value("reset_wb_valid", 32'd0, 32'(wb_o.valid));
            #5;
            foreach (lines[i])
                run_line(lines[i]);
            repeat (10) @(posedge clock);
            foreach (missing[i])
                $display("No writeback arrived for %s", missing[i]);
            total = errors + mon_errors + missing.size();
            $display("Errors: %0d (checks %0d, tracker %0d, missing %0d)",
                     total, errors, mon_errors, missing.size());
            if (total == 0)
                $display("TESTS PASSED");
            else
                $display("TESTS FAILED");
            $finish;
        end
    end

endmodule
